// ==== rtl/cpu_defines.svh ====
// global sizing constants shared by the processor and its testbench

`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// datapath and instruction width
`define CPU_WORD_W 32

// architectural register count
`define CPU_REG_N 32

`define CPU_PC_INIT 32'h0000_0000   // first fetch address after reset

// external RAM size in words
`define CPU_RAM_WORDS 1024

`endif

// ==== rtl/cpu_types_pkg.sv ====
// instruction set types for the MIPS subset pipeline
`default_nettype none
`include "cpu_defines.svh"

package cpu_types_pkg;

   typedef logic [`CPU_WORD_W-1:0]        word_t;
   typedef logic [$clog2(`CPU_REG_N)-1:0] regbits_t;

   // primary opcodes, instr[31:26]
   typedef enum logic [5:0] {
      RTYPE = 6'b000000,
      J     = 6'b000010,
      BEQ   = 6'b000100,
      BNE   = 6'b000101,
      ADDIU = 6'b001001,
      ORI   = 6'b001101,
      LUI   = 6'b001111,
      LW    = 6'b100011,
      SW    = 6'b101011,
      HALT  = 6'b111111
   } opcode_t;

   // r-type function codes, instr[5:0]
   typedef enum logic [5:0] {
      FN_ADDU = 6'b100001,
      FN_SUBU = 6'b100011,
      FN_AND  = 6'b100100,
      FN_OR   = 6'b100101,
      FN_XOR  = 6'b100110,
      FN_SLT  = 6'b101010
   } funct_t;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_LUI
   } aluop_t;

endpackage

`default_nettype wire

// ==== rtl/mem_bus_pkg.sv ====
// memory bus types shared by the requesters and the RAM arbiter
`default_nettype none
`include "cpu_defines.svh"

package mem_bus_pkg;

   typedef logic [`CPU_WORD_W-1:0] addr_t;   // byte address, word aligned

   typedef enum logic [1:0] {
      ARB_IDLE, ARB_FETCH, ARB_DATA
   } arb_state_t;

endpackage

`default_nettype wire

// ==== rtl/mem_port_if.sv ====
// one requester to arbiter memory port with request levels and a wait flag
`timescale 1ns/10ps
`default_nettype none

interface mem_port_if;
   logic                 ren;
   logic                 wen;
   mem_bus_pkg::addr_t   addr;
   cpu_types_pkg::word_t wdata;
   cpu_types_pkg::word_t rdata;
   logic                 mwait;   // memory wait, low in the completing cycle

   modport requester (output ren, wen, addr, wdata, input rdata, mwait);
   modport arbiter (input ren, wen, addr, wdata, output rdata, mwait);
endinterface

`default_nettype wire

// ==== rtl/register_file.sv ====
// register file with a hardwired zero register and same-cycle write bypass
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defines.svh"

module register_file (
   input  logic                    CLK,
   input  logic                    nRST,
   input  cpu_types_pkg::regbits_t rsel1,
   input  cpu_types_pkg::regbits_t rsel2,
   input  logic                    wen,
   input  cpu_types_pkg::regbits_t wsel,
   input  cpu_types_pkg::word_t    wdat,
   output cpu_types_pkg::word_t    rdat1,
   output cpu_types_pkg::word_t    rdat2
);
   cpu_types_pkg::word_t regs [`CPU_REG_N];

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         for (int i = 0; i < `CPU_REG_N; i++)
            regs[i] <= '0;
      end else if (wen && wsel != '0) begin
         regs[wsel] <= wdat;
      end
   end

   // writeback data visible to decode in the same cycle
   assign rdat1 = (rsel1 == '0) ? '0 : (wen && wsel == rsel1) ? wdat : regs[rsel1];
   assign rdat2 = (rsel2 == '0) ? '0 : (wen && wsel == rsel2) ? wdat : regs[rsel2];
endmodule

`default_nettype wire

// ==== rtl/control_unit.sv ====
// instruction decoder producing the control fields carried down the pipe
`timescale 1ns/10ps
`default_nettype none

module control_unit (
   input  cpu_types_pkg::word_t    instr,
   output cpu_types_pkg::aluop_t   alu_op,
   output logic                    alu_src,
   output logic                    ext_sign,
   output logic                    reg_dst,
   output logic                    reg_wr,
   output logic                    mem_rd,
   output logic                    mem_wr,
   output logic                    branch_eq,
   output logic                    branch_ne,
   output logic                    jump,
   output logic                    halt,
   output cpu_types_pkg::regbits_t rs,
   output cpu_types_pkg::regbits_t rt,
   output cpu_types_pkg::regbits_t rd,
   output logic [15:0]             imm16
);
   cpu_types_pkg::opcode_t opcode;
   cpu_types_pkg::funct_t  funct;

   assign opcode = cpu_types_pkg::opcode_t'(instr[31:26]);
   assign funct  = cpu_types_pkg::funct_t'(instr[5:0]);
   assign rs     = instr[25:21];
   assign rt     = instr[20:16];
   assign rd     = instr[15:11];
   assign imm16  = instr[15:0];

   always_comb begin
      alu_op = cpu_types_pkg::ALU_ADD;
      {alu_src, ext_sign, reg_dst, reg_wr, mem_rd, mem_wr} = '0;
      {branch_eq, branch_ne, jump, halt} = '0;
      case (opcode)
         cpu_types_pkg::RTYPE: begin
            reg_dst = 1'b1;
            reg_wr  = 1'b1;
            case (funct)
               cpu_types_pkg::FN_ADDU: alu_op = cpu_types_pkg::ALU_ADD;
               cpu_types_pkg::FN_SUBU: alu_op = cpu_types_pkg::ALU_SUB;
               cpu_types_pkg::FN_AND:  alu_op = cpu_types_pkg::ALU_AND;
               cpu_types_pkg::FN_OR:   alu_op = cpu_types_pkg::ALU_OR;
               cpu_types_pkg::FN_XOR:  alu_op = cpu_types_pkg::ALU_XOR;
               cpu_types_pkg::FN_SLT:  alu_op = cpu_types_pkg::ALU_SLT;
               default:                reg_wr = 1'b0;   // also covers the all-zero nop
            endcase
         end
         cpu_types_pkg::ADDIU: {alu_src, ext_sign, reg_wr} = 3'b111;
         cpu_types_pkg::ORI: begin
            alu_op  = cpu_types_pkg::ALU_OR;
            alu_src = 1'b1;   // zero extended
            reg_wr  = 1'b1;
         end
         cpu_types_pkg::LUI: begin
            alu_op  = cpu_types_pkg::ALU_LUI;
            alu_src = 1'b1;
            reg_wr  = 1'b1;
         end
         cpu_types_pkg::LW:  {alu_src, ext_sign, reg_wr, mem_rd} = 4'b1111;
         cpu_types_pkg::SW:  {alu_src, ext_sign, mem_wr} = 3'b111;
         cpu_types_pkg::BEQ: {ext_sign, branch_eq} = 2'b11;
         cpu_types_pkg::BNE: {ext_sign, branch_ne} = 2'b11;
         cpu_types_pkg::J:    jump = 1'b1;
         cpu_types_pkg::HALT: halt = 1'b1;
         default: ;   // unknown opcode, no-operation
      endcase
   end
endmodule

`default_nettype wire

// ==== rtl/datapath.sv ====
// five stage pipeline with forwarding, load-use stall, flush and two memory ports
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defines.svh"

module datapath (
   input  logic          CLK,
   input  logic          nRST,
   mem_port_if.requester imem,
   mem_port_if.requester dmem,
   output logic          halt
);
   typedef struct packed {
      cpu_types_pkg::word_t instr;
      cpu_types_pkg::word_t npc;
   } fd_t;

   typedef struct packed {
      cpu_types_pkg::word_t    npc, rdat1, rdat2, imm;
      logic [25:0]             jaddr;
      cpu_types_pkg::regbits_t rs, rt, wsel;
      cpu_types_pkg::aluop_t   alu_op;
      logic                    alu_src, reg_wr, mem_rd, mem_wr;
      logic                    branch_eq, branch_ne, jump, halt;
   } de_t;

   typedef struct packed {
      cpu_types_pkg::word_t    alu_res, store;
      cpu_types_pkg::regbits_t wsel;
      logic                    reg_wr, mem_rd, mem_wr, halt;
   } em_t;

   typedef struct packed {
      cpu_types_pkg::word_t    wdat;
      cpu_types_pkg::regbits_t wsel;
      logic                    reg_wr, halt;
   } mw_t;

   mem_bus_pkg::addr_t      pc;
   fd_t                     fd, fd_d;
   de_t                     de, de_d;
   em_t                     em, em_d;
   mw_t                     mw, mw_d;
   cpu_types_pkg::aluop_t   alu_op;
   logic                    alu_src, ext_sign, reg_dst, reg_wr, mem_rd, mem_wr;
   logic                    branch_eq, branch_ne, jump, dec_halt;
   cpu_types_pkg::regbits_t rs, rt, rd;
   logic [15:0]             imm16;
   cpu_types_pkg::word_t    rdat1, rdat2, fwd_a, fwd_b, op_b, alu_res, target;
   cpu_types_pkg::word_t    iload, dload;
   logic                    redirect, load_use, advance, idone, ddone;

   // memory stage wins over writeback
   function automatic cpu_types_pkg::word_t forward(input cpu_types_pkg::regbits_t r,
                                                    input cpu_types_pkg::word_t rf_val,
                                                    input em_t e, input mw_t m);
      if (e.reg_wr && e.wsel != '0 && e.wsel == r)
         return e.alu_res;
      if (m.reg_wr && m.wsel != '0 && m.wsel == r)
         return m.wdat;
      return rf_val;
   endfunction

   control_unit u_control_unit (
      .instr(fd.instr), .alu_op, .alu_src, .ext_sign, .reg_dst, .reg_wr, .mem_rd, .mem_wr,
      .branch_eq, .branch_ne, .jump, .halt(dec_halt), .rs, .rt, .rd, .imm16
   );

   register_file u_register_file (
      .CLK, .nRST, .rsel1(rs), .rsel2(rt), .wen(mw.reg_wr), .wsel(mw.wsel), .wdat(mw.wdat),
      .rdat1, .rdat2
   );

   //////////////////////////////////////////////////
   // memory ports and back-pressure
   //////////////////////////////////////////////////
   assign imem.ren   = !halt && !idone;
   assign imem.wen   = 1'b0;   // fetch only reads
   assign imem.addr  = pc;
   assign imem.wdata = '0;
   assign dmem.ren   = em.mem_rd && !ddone;
   assign dmem.wen   = em.mem_wr && !ddone;
   assign dmem.addr  = em.alu_res;
   assign dmem.wdata = em.store;

   assign advance = !(imem.ren && imem.mwait) && !((dmem.ren || dmem.wen) && dmem.mwait);

   // a port that finished early drops its request until the whole pipe moves
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         idone <= 1'b0;
         ddone <= 1'b0;
      end else if (advance) begin
         idone <= 1'b0;
         ddone <= 1'b0;
      end else begin
         if (imem.ren && !imem.mwait)
            idone <= 1'b1;
         if ((dmem.ren || dmem.wen) && !dmem.mwait)
            ddone <= 1'b1;
      end
   end

   always_ff @(posedge CLK) begin
      if (!idone)
         iload <= imem.rdata;
      if (!ddone)
         dload <= dmem.rdata;
   end

   //////////////////////////////////////////////////
   // stage logic
   //////////////////////////////////////////////////
   assign fd_d.instr = halt ? '0 : (idone ? iload : imem.rdata);
   assign fd_d.npc   = pc + 4;

   assign load_use = de.mem_rd && de.wsel != '0 && (de.wsel == rs || de.wsel == rt);

   always_comb begin
      de_d.npc    = fd.npc;
      de_d.rdat1  = rdat1;
      de_d.rdat2  = rdat2;
      de_d.imm    = ext_sign ? {{(`CPU_WORD_W-16){imm16[15]}}, imm16}
                             : {{(`CPU_WORD_W-16){1'b0}}, imm16};
      de_d.jaddr  = fd.instr[25:0];
      de_d.rs     = rs;
      de_d.rt     = rt;
      de_d.wsel   = reg_dst ? rd : rt;   // rd for r-type
      de_d.alu_op = alu_op;
      {de_d.alu_src, de_d.reg_wr} = {alu_src, reg_wr};
      {de_d.mem_rd, de_d.mem_wr, de_d.halt} = {mem_rd, mem_wr, dec_halt};
      {de_d.branch_eq, de_d.branch_ne, de_d.jump} = {branch_eq, branch_ne, jump};
   end

   always_comb begin
      fwd_a = forward(de.rs, de.rdat1, em, mw);
      fwd_b = forward(de.rt, de.rdat2, em, mw);
      op_b  = de.alu_src ? de.imm : fwd_b;
      case (de.alu_op)
         cpu_types_pkg::ALU_SUB: alu_res = fwd_a - op_b;
         cpu_types_pkg::ALU_AND: alu_res = fwd_a & op_b;
         cpu_types_pkg::ALU_OR:  alu_res = fwd_a | op_b;
         cpu_types_pkg::ALU_XOR: alu_res = fwd_a ^ op_b;
         cpu_types_pkg::ALU_SLT:
            alu_res = {{(`CPU_WORD_W-1){1'b0}}, $signed(fwd_a) < $signed(op_b)};
         cpu_types_pkg::ALU_LUI: alu_res = {op_b[15:0], 16'h0000};
         default:                alu_res = fwd_a + op_b;
      endcase
   end

   // branches compare the forwarded operands
   assign redirect = de.jump || (de.branch_eq && fwd_a == fwd_b) ||
                     (de.branch_ne && fwd_a != fwd_b);
   assign target   = de.jump ? {de.npc[`CPU_WORD_W-1:28], de.jaddr, 2'b00}
                             : de.npc + {de.imm[`CPU_WORD_W-3:0], 2'b00};

   assign em_d = '{alu_res: alu_res, store: fwd_b, wsel: de.wsel, reg_wr: de.reg_wr,
                   mem_rd: de.mem_rd, mem_wr: de.mem_wr, halt: de.halt};
   assign mw_d = '{wdat: em.mem_rd ? (ddone ? dload : dmem.rdata) : em.alu_res,
                   wsel: em.wsel, reg_wr: em.reg_wr, halt: em.halt};

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         pc <= `CPU_PC_INIT;
         fd <= '0;
         de <= '0;
         em <= '0;
         mw <= '0;
      end else if (advance) begin
         em <= em_d;
         mw <= mw_d;
         if (redirect) begin   // squash the two younger stages
            pc <= target;
            fd <= '0;
            de <= '0;
         end else if (load_use) begin
            de <= '0;          // bubble while fetch and decode hold
         end else begin
            pc <= fd_d.npc;
            fd <= fd_d;
            de <= de_d;
         end
      end
   end

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST)
         halt <= 1'b0;
      else if (advance && mw.halt)
         halt <= 1'b1;
   end
endmodule

`default_nettype wire

// ==== rtl/mem_arbiter.sv ====
// RAM bus arbiter granting one access at a time, data port before fetch port
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
   input  logic                 CLK,
   input  logic                 nRST,
   mem_port_if.arbiter          fetch,
   mem_port_if.arbiter          data,
   output logic                 ram_ren,
   output logic                 ram_wen,
   output mem_bus_pkg::addr_t   ram_addr,
   output cpu_types_pkg::word_t ram_wdata,
   input  cpu_types_pkg::word_t ram_rdata,
   input  logic                 ram_ready
);
   mem_bus_pkg::arb_state_t state, next_state;
   logic                    freq, dreq;

   assign freq = fetch.ren || fetch.wen;
   assign dreq = data.ren || data.wen;

   //////////////////////////////////////////////////
   // grant FSM
   //////////////////////////////////////////////////
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST)
         state <= mem_bus_pkg::ARB_IDLE;
      else
         state <= next_state;
   end

   always_comb begin
      next_state = state;
      case (state)
         mem_bus_pkg::ARB_IDLE: begin
            if (dreq)
               next_state = mem_bus_pkg::ARB_DATA;
            else if (freq)
               next_state = mem_bus_pkg::ARB_FETCH;
         end
         mem_bus_pkg::ARB_FETCH, mem_bus_pkg::ARB_DATA: begin
            if (ram_ready)
               next_state = mem_bus_pkg::ARB_IDLE;
         end
         default: next_state = mem_bus_pkg::ARB_IDLE;
      endcase
   end

   // bus mux, quiet when idle
   always_comb begin
      {ram_ren, ram_wen, ram_addr, ram_wdata} = '0;
      case (state)
         mem_bus_pkg::ARB_FETCH:
            {ram_ren, ram_wen, ram_addr, ram_wdata} = {fetch.ren, fetch.wen, fetch.addr, fetch.wdata};
         mem_bus_pkg::ARB_DATA:
            {ram_ren, ram_wen, ram_addr, ram_wdata} = {data.ren, data.wen, data.addr, data.wdata};
         default: ;
      endcase
   end

   assign fetch.rdata = ram_rdata;
   assign data.rdata  = ram_rdata;
   assign fetch.mwait = freq && !(state == mem_bus_pkg::ARB_FETCH && ram_ready);
   assign data.mwait  = dreq && !(state == mem_bus_pkg::ARB_DATA && ram_ready);
endmodule

`default_nettype wire

// ==== rtl/cpu_top.sv ====
// processor top level joining the pipeline to the shared RAM bus
`timescale 1ns/10ps
`default_nettype none

module cpu_top (
   input  logic                 CLK,
   input  logic                 nRST,
   output logic                 ram_ren,
   output logic                 ram_wen,
   output mem_bus_pkg::addr_t   ram_addr,
   output cpu_types_pkg::word_t ram_wdata,
   input  cpu_types_pkg::word_t ram_rdata,
   input  logic                 ram_ready,
   output logic                 halt
);
   mem_port_if imem_port ();
   mem_port_if dmem_port ();

   datapath u_datapath (
      .CLK, .nRST,
      .imem(imem_port),
      .dmem(dmem_port),
      .halt
   );

   // fetch and data requesters share one RAM
   mem_arbiter u_mem_arbiter (
      .CLK, .nRST,
      .fetch(imem_port),
      .data(dmem_port),
      .ram_ren, .ram_wen, .ram_addr, .ram_wdata,
      .ram_rdata, .ram_ready
   );
endmodule

`default_nettype wire

// ==== testbench/tb_iss_pkg.sv ====
// random program generator and instruction-level reference model for the processor
`default_nettype none
`include "cpu_defines.svh"

package tb_iss_pkg;

   localparam int addr_w    = $clog2(`CPU_RAM_WORDS);
   localparam int data_word = 512;    // load and store region
   localparam int dump_word = 1000;   // register dump area

   cpu_types_pkg::word_t init_image [`CPU_RAM_WORDS];
   cpu_types_pkg::word_t final_image [`CPU_RAM_WORDS];
   mem_bus_pkg::addr_t   store_addr [$];   // ordered store stream
   cpu_types_pkg::word_t store_data [$];
   int                   prog_len;

   function automatic cpu_types_pkg::word_t rtype_word(input cpu_types_pkg::funct_t fn,
                                                       input int rs, input int rt,
                                                       input int rd);
      return {6'b000000, 5'(rs), 5'(rt), 5'(rd), 5'b00000, fn};
   endfunction

   function automatic cpu_types_pkg::word_t itype_word(input cpu_types_pkg::opcode_t op,
                                                       input int rs, input int rt,
                                                       input logic [15:0] imm);
      return {op, 5'(rs), 5'(rt), imm};
   endfunction

   function automatic cpu_types_pkg::word_t jump_word(input int target);
      return {cpu_types_pkg::J, 26'(target)};   // word index of the target
   endfunction

   //////////////////////////////////////////////////
   // program builder
   //////////////////////////////////////////////////
   function automatic void build_program();
      cpu_types_pkg::funct_t fns [6];
      int                    body;
      int                    kind;
      int                    rs;
      int                    rt;
      int                    rd;
      logic [15:0]           imm;
      fns = '{cpu_types_pkg::FN_ADDU, cpu_types_pkg::FN_SUBU, cpu_types_pkg::FN_AND,
              cpu_types_pkg::FN_OR, cpu_types_pkg::FN_XOR, cpu_types_pkg::FN_SLT};
      foreach (init_image[i])
         init_image[i] = (i >= data_word) ? (32'h5a00_0000 ^ (i * 32'h9e37_79b1)) : '0;
      body = $urandom_range(40, 60);
      for (int i = 0; i < body; i++) begin
         kind = $urandom_range(0, 13);
         rs   = $urandom_range(1, 7);   // few registers, dense dependences
         rt   = $urandom_range(1, 7);
         rd   = $urandom_range(1, 7);
         imm  = 16'($urandom);
         if (kind < 6) begin
            init_image[i] = rtype_word(fns[kind], rs, rt, rd);
         end else begin
            case (kind)
               6:  init_image[i] = itype_word(cpu_types_pkg::ADDIU, rs, rt, imm);
               7:  init_image[i] = itype_word(cpu_types_pkg::ORI, rs, rt, imm);
               8:  init_image[i] = itype_word(cpu_types_pkg::LUI, 0, rt, imm);
               9:  init_image[i] = itype_word(cpu_types_pkg::LW, 0, rt,
                                              16'(4 * (data_word + $urandom_range(0, 15))));
               10: init_image[i] = itype_word(cpu_types_pkg::SW, 0, rt,
                                              16'(4 * (data_word + $urandom_range(0, 15))));
               11: init_image[i] = itype_word(cpu_types_pkg::BEQ, rs, rt,
                                              16'($urandom_range(1, 3)));
               12: init_image[i] = itype_word(cpu_types_pkg::BNE, rs, rt,
                                              16'($urandom_range(1, 3)));
               default: init_image[i] = jump_word(i + 1 + $urandom_range(1, 3));
            endcase
         end
      end
      for (int r = 1; r <= 7; r++)
         init_image[body + r - 1] = itype_word(cpu_types_pkg::SW, 0, r, 16'(4 * (dump_word + r)));
      init_image[body + 7] = {cpu_types_pkg::HALT, 26'h0};
      prog_len = body + 8;
   endfunction

   //////////////////////////////////////////////////
   // reference model, one instruction per step
   //////////////////////////////////////////////////
   function automatic void run_model();
      cpu_types_pkg::word_t regs [`CPU_REG_N];
      cpu_types_pkg::word_t w;
      cpu_types_pkg::word_t a;
      cpu_types_pkg::word_t b;
      cpu_types_pkg::word_t simm;
      mem_bus_pkg::addr_t   pc;
      mem_bus_pkg::addr_t   npc;
      mem_bus_pkg::addr_t   ea;
      final_image = init_image;
      regs = '{default: '0};
      store_addr.delete();
      store_data.delete();
      pc = `CPU_PC_INIT;
      for (int step = 0; step < `CPU_RAM_WORDS; step++) begin
         w    = final_image[pc[addr_w+1:2]];
         a    = regs[w[25:21]];
         b    = regs[w[20:16]];
         simm = {{16{w[15]}}, w[15:0]};
         ea   = a + simm;
         npc  = pc + 4;
         pc   = npc;   // no delay slot
         case (cpu_types_pkg::opcode_t'(w[31:26]))
            cpu_types_pkg::RTYPE: begin
               case (cpu_types_pkg::funct_t'(w[5:0]))
                  cpu_types_pkg::FN_ADDU: regs[w[15:11]] = a + b;
                  cpu_types_pkg::FN_SUBU: regs[w[15:11]] = a - b;
                  cpu_types_pkg::FN_AND:  regs[w[15:11]] = a & b;
                  cpu_types_pkg::FN_OR:   regs[w[15:11]] = a | b;
                  cpu_types_pkg::FN_XOR:  regs[w[15:11]] = a ^ b;
                  cpu_types_pkg::FN_SLT:  regs[w[15:11]] = ($signed(a) < $signed(b)) ? 1 : 0;
                  default: ;
               endcase
            end
            cpu_types_pkg::ADDIU: regs[w[20:16]] = a + simm;
            cpu_types_pkg::ORI:   regs[w[20:16]] = a | {16'h0000, w[15:0]};
            cpu_types_pkg::LUI:   regs[w[20:16]] = {w[15:0], 16'h0000};
            cpu_types_pkg::LW:    regs[w[20:16]] = final_image[ea[addr_w+1:2]];
            cpu_types_pkg::SW: begin
               final_image[ea[addr_w+1:2]] = b;
               store_addr.push_back(ea);
               store_data.push_back(b);
            end
            cpu_types_pkg::BEQ: if (a == b) pc = npc + {simm[29:0], 2'b00};
            cpu_types_pkg::BNE: if (a != b) pc = npc + {simm[29:0], 2'b00};
            cpu_types_pkg::J:   pc = {npc[31:28], w[25:0], 2'b00};
            cpu_types_pkg::HALT: return;
            default: ;
         endcase
         regs[0] = '0;
      end
   endfunction

endpackage

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
// free-running clock source for the processor testbench
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
   parameter real period_ns = 10.0
) (
   output logic CLK
);
   initial begin
      CLK = 1'b0;
      forever #(period_ns / 2.0) CLK = ~CLK;   // 50 percent duty
   end
endmodule

`default_nettype wire

// ==== testbench/tb_cpu_top.sv ====
// testbench for the pipelined processor with a delayed RAM model and a store stream checker
`timescale 1ns/10ps
`default_nettype none
`include "cpu_defines.svh"

module tb_cpu_top;
   localparam int addr_w    = $clog2(`CPU_RAM_WORDS);
   localparam int max_delay = 4;   // longest RAM delay in cycles

   logic                 CLK;
   logic                 nRST;
   logic                 ram_ren, ram_wen, halt;
   logic                 ram_ready = 1'b0;
   mem_bus_pkg::addr_t   ram_addr;
   cpu_types_pkg::word_t ram_wdata;
   cpu_types_pkg::word_t ram_rdata = '0;
   cpu_types_pkg::word_t ram [`CPU_RAM_WORDS];
   logic                 busy = 1'b0;
   int                   delay;
   int                   store_cnt = 0;
   bit                   fetch_seen = 1'b0;
   bit                   halt_seen = 1'b0;
   bit                   prog_ready = 1'b0;
   int unsigned          limit_cycles;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("RESULT: FAIL");
      $fatal(1, "run aborted");
   endtask

   task automatic check_addr(input string name, input mem_bus_pkg::addr_t got,
                             input mem_bus_pkg::addr_t exp);
      if (got !== exp) begin
         $display("ERR %s got %h expected %h", name, got, exp);
         $display("RESULT: FAIL");
         $fatal(1, "address mismatch");
      end
   endtask

   task automatic check_word(input string name, input cpu_types_pkg::word_t got,
                             input cpu_types_pkg::word_t exp);
      if (got !== exp) begin
         $display("ERR %s got %h expected %h", name, got, exp);
         $display("RESULT: FAIL");
         $fatal(1, "data mismatch");
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERR %s got %h expected %h", name, got, exp);
         $display("RESULT: FAIL");
         $fatal(1, "flag mismatch");
      end
   endtask

   tb_clock_gen u_tb_clock_gen (.CLK);

   cpu_top u_cpu_top (
      .CLK, .nRST,
      .ram_ren, .ram_wen, .ram_addr, .ram_wdata,
      .ram_rdata, .ram_ready,
      .halt
   );

   //////////////////////////////////////////////////
   // RAM model giving one ready pulse per access
   //////////////////////////////////////////////////
   always @(posedge CLK) begin
      if (!nRST) begin
         ram       <= tb_iss_pkg::init_image;   // program and data fill
         busy      <= 1'b0;
         ram_ready <= 1'b0;
      end else begin
         ram_ready <= 1'b0;
         if (ram_ready && ram_wen)
            ram[ram_addr[addr_w+1:2]] <= ram_wdata;   // write lands at the pulse
         if (busy) begin
            if (delay <= 1) begin
               ram_ready <= 1'b1;
               ram_rdata <= ram[ram_addr[addr_w+1:2]];
               busy      <= 1'b0;
            end else begin
               delay <= delay - 1;
            end
         end else if ((ram_ren || ram_wen) && !ram_ready) begin
            busy  <= 1'b1;
            delay <= $urandom_range(1, max_delay);
         end
      end
   end

   // bus checks at the falling edge where outputs are stable
   always @(negedge CLK) begin
      if (!fetch_seen) begin
         check_flag("ram_wen", ram_wen, 1'b0);
         check_flag("halt", halt, 1'b0);
         if (!nRST)
            check_flag("ram_ren", ram_ren, 1'b0);   // bus quiet in reset
         if (ram_ren) begin
            check_addr("ram_addr", ram_addr, `CPU_PC_INIT);
            fetch_seen = 1'b1;
         end
      end
      if (halt_seen) begin
         check_flag("halt", halt, 1'b1);
         check_flag("ram_wen", ram_wen, 1'b0);   // no store after halt
         check_flag("ram_ren", ram_ren, 1'b0);   // fetch stops once halted
      end
      if (ram_ready && ram_wen) begin
         if (store_cnt >= tb_iss_pkg::store_addr.size()) begin
            abort_run("the DUT stored more words than the model did");
         end else begin
            check_addr("ram_addr", ram_addr, tb_iss_pkg::store_addr[store_cnt]);
            check_word("ram_wdata", ram_wdata, tb_iss_pkg::store_data[store_cnt]);
            store_cnt++;
         end
      end
   end

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////
   initial begin
      nRST = 1'b0;
      void'($urandom(31649));
      tb_iss_pkg::build_program();
      tb_iss_pkg::run_model();
      limit_cycles = tb_iss_pkg::prog_len * 200 * max_delay;
      prog_ready   = 1'b1;
      repeat (8) @(posedge CLK);
      nRST <= 1'b1;
      wait (halt === 1'b1);
      halt_seen = 1'b1;
      check_word("store_count", cpu_types_pkg::word_t'(store_cnt),
                 cpu_types_pkg::word_t'(tb_iss_pkg::store_addr.size()));
      repeat (20) @(posedge CLK);   // halt holds and the bus stays quiet
      foreach (ram[i])
         check_word($sformatf("ram[%0d]", i), ram[i], tb_iss_pkg::final_image[i]);
      $display("RESULT: PASS");
      $finish;
   end

   // watchdog allowing 200 cycles per instruction at the longest RAM delay
   initial begin
      wait (prog_ready);
      repeat (limit_cycles) @(posedge CLK);
      abort_run("the run timed out before the processor halted");
   end
endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+rtl
rtl/cpu_types_pkg.sv
rtl/mem_bus_pkg.sv
rtl/mem_port_if.sv
rtl/register_file.sv
rtl/control_unit.sv
rtl/datapath.sv
rtl/mem_arbiter.sv
rtl/cpu_top.sv
testbench/tb_iss_pkg.sv
testbench/tb_clock_gen.sv
testbench/tb_cpu_top.sv

// ==== Makefile ====
# Verilator build and run of the pipelined processor testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
